// File: hw/row_mem_pkg.sv
package row_mem_pkg;

    // ----------------------------------------------------------------------
    // row memory counts
    // ----------------------------------------------------------------------
    localparam int NUM_ACT_ROW_MEM = 96;
    localparam int NUM_WGT_ROW_MEM = 3;

    // row counter widths
    localparam int ACT_ROW_IDX_W   = 7;
    localparam int WGT_ROW_IDX_W   = 2;

    // ----------------------------------------------------------------------
    // sample and address types
    // ----------------------------------------------------------------------
    typedef logic signed [7:0] sample_t;

    // flat stream addresses
    typedef logic [12:0] act_addr_t;
    typedef logic [9:0]  wgt_addr_t;

    // address inside one row memory, also the input image height and width
    typedef logic [6:0]  act_row_addr_t;
    typedef logic [7:0]  wgt_row_addr_t;

    // one-hot row memory selects
    typedef logic [NUM_ACT_ROW_MEM-1:0] act_sel_t;
    typedef logic [NUM_WGT_ROW_MEM-1:0] wgt_sel_t;

    // ----------------------------------------------------------------------
    // layer configuration
    // ----------------------------------------------------------------------
    typedef logic [7:0] oc_t;

    // output image height or width
    typedef logic [5:0] img_dim_t;

    // kernel size or stride
    typedef logic [2:0] kern_t;

    // load sequence
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        DONE
    } load_state_t;

endpackage

// File: hw/load_cfg_if.sv
`timescale 1ns/10ps

interface load_cfg_if import row_mem_pkg::*; ();

    // derived geometry, stable while loading
    act_row_addr_t in_img_w;
    kern_t         k;

    // load status
    logic          load_active;

    // aligned with the registered stream addresses in the scatter units
    logic          act_end;
    logic          wgt_end;

    modport ctrl (
        output in_img_w,
        output k,
        output load_active,
        output act_end,
        output wgt_end
    );

    modport scatter (
        input  in_img_w,
        input  k,
        input  load_active,
        input  act_end,
        input  wgt_end
    );

endinterface

// File: hw/load_ctrl.sv
`timescale 1ns/10ps

module load_ctrl import row_mem_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    input  oc_t       oc,
    input  img_dim_t  img_h,
    input  img_dim_t  img_w,
    input  kern_t     k,
    input  kern_t     stride,
    input  act_addr_t act_addr,
    input  wgt_addr_t wgt_addr,
    output logic      done,
    load_cfg_if.ctrl  cfg
);

    act_row_addr_t in_img_h;
    act_row_addr_t in_img_w;
    act_addr_t     act_total;
    wgt_addr_t     wgt_total;
    logic          streams_done;
    logic          act_end_q;
    logic          wgt_end_q;
    load_state_t   state;
    load_state_t   state_nxt;

    // ----------------------------------------------------------------------
    // input geometry
    // ----------------------------------------------------------------------
    // (out - 1) * stride + k, computed at the row address width
    assign in_img_h = (act_row_addr_t'(img_h) - act_row_addr_t'(1)) * act_row_addr_t'(stride)
                      + act_row_addr_t'(k);
    assign in_img_w = (act_row_addr_t'(img_w) - act_row_addr_t'(1)) * act_row_addr_t'(stride)
                      + act_row_addr_t'(k);

    // samples per stream
    assign act_total = act_addr_t'(in_img_h) * act_addr_t'(in_img_w);
    assign wgt_total = wgt_addr_t'(k) * wgt_addr_t'(k) * wgt_addr_t'(oc);

    // ----------------------------------------------------------------------
    // load sequence
    // ----------------------------------------------------------------------
    // raw port addresses, so DONE follows one cycle after both ends
    assign streams_done = (act_addr >= act_total) && (wgt_addr >= wgt_total);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_nxt = LOAD;
                end
            end
            LOAD: begin
                if (streams_done) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ----------------------------------------------------------------------
    // end-of-stream flags
    // ----------------------------------------------------------------------
    // registered once, so they line up with the scatter input slice
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            act_end_q <= 1'b0;
            wgt_end_q <= 1'b0;
        end else begin
            act_end_q <= (act_addr >= act_total - act_addr_t'(1));
            wgt_end_q <= (wgt_addr >= wgt_total);
        end
    end

    assign done            = (state == DONE);
    assign cfg.in_img_w    = in_img_w;
    assign cfg.k           = k;
    assign cfg.load_active = (state == LOAD);
    assign cfg.act_end     = act_end_q;
    assign cfg.wgt_end     = wgt_end_q;

endmodule

// File: hw/act_row_scatter.sv
`timescale 1ns/10ps

module act_row_scatter import row_mem_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  sample_t       act_data,
    input  act_addr_t     act_addr,
    output sample_t       act_row_data,
    output act_row_addr_t act_row_addr,
    output act_sel_t      act_row_en,
    output act_sel_t      act_row_we,
    load_cfg_if.scatter   cfg
);

    sample_t                  data_q;
    act_addr_t                addr_q;
    act_row_addr_t            col;
    logic                     col_wrap;
    logic                     past_end;
    logic [ACT_ROW_IDX_W-1:0] row_cnt;
    sample_t                  row_data_q;
    act_row_addr_t            row_addr_q;
    act_sel_t                 row_sel_q;

    // ----------------------------------------------------------------------
    // input slice
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        data_q <= act_data;
        addr_q <= act_addr;
    end

    // ----------------------------------------------------------------------
    // column and row tracking
    // ----------------------------------------------------------------------
    assign col = act_row_addr_t'(addr_q % act_addr_t'(cfg.in_img_w));

    // the held address past the end must not move the row again
    assign col_wrap = (col == cfg.in_img_w - act_row_addr_t'(1)) && !past_end;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            row_cnt    <= '0;
            past_end   <= 1'b0;
            row_data_q <= '0;
            row_addr_q <= '0;
            row_sel_q  <= '0;
        end else if (cfg.load_active) begin
            row_data_q <= data_q;
            row_addr_q <= col;
            // one image row per memory
            row_sel_q  <= act_sel_t'(1) << row_cnt;
            past_end   <= cfg.act_end;
            if (col_wrap) begin
                row_cnt <= row_cnt + ACT_ROW_IDX_W'(1);
            end
        end else begin
            // outside LOAD everything returns to zero
            row_cnt    <= '0;
            past_end   <= 1'b0;
            row_data_q <= '0;
            row_addr_q <= '0;
            row_sel_q  <= '0;
        end
    end

    assign act_row_data = row_data_q;
    assign act_row_addr = row_addr_q;

    // every enabled memory is written
    assign act_row_en   = row_sel_q;
    assign act_row_we   = row_sel_q;

endmodule

// File: hw/weight_row_scatter.sv
`timescale 1ns/10ps

module weight_row_scatter import row_mem_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  sample_t       wgt_data,
    input  wgt_addr_t     wgt_addr,
    output sample_t       wgt_row_data,
    output wgt_row_addr_t wgt_row_addr,
    output wgt_sel_t      wgt_row_en,
    output wgt_sel_t      wgt_row_we,
    load_cfg_if.scatter   cfg
);

    sample_t                  data_q;
    wgt_addr_t                addr_q;
    wgt_addr_t                k_ext;
    wgt_addr_t                kk;
    wgt_addr_t                in_kern;
    wgt_addr_t                in_plane;
    logic [WGT_ROW_IDX_W-1:0] kern_row;
    logic                     oc_wrap;
    oc_t                      oc_cnt;
    sample_t                  row_data_q;
    wgt_row_addr_t            row_addr_q;
    wgt_sel_t                 row_sel_q;

    // ----------------------------------------------------------------------
    // input slice
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        data_q <= wgt_data;
        addr_q <= wgt_addr;
    end

    // ----------------------------------------------------------------------
    // address folding
    // ----------------------------------------------------------------------
    assign k_ext = wgt_addr_t'(cfg.k);
    assign kk    = k_ext * k_ext;

    // position inside one kernel row and inside one K x K plane
    assign in_kern  = addr_q % k_ext;
    assign in_plane = addr_q % kk;

    // kernel row of the sample picks the memory
    assign kern_row = WGT_ROW_IDX_W'((addr_q / k_ext) % k_ext);

    // next output channel after the last sample of a plane
    assign oc_wrap = (in_plane == kk - wgt_addr_t'(1)) && !cfg.wgt_end;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            oc_cnt     <= '0;
            row_data_q <= '0;
            row_addr_q <= '0;
            row_sel_q  <= '0;
        end else if (cfg.load_active) begin
            row_data_q <= data_q;
            // channels are stacked K entries apart in each row memory
            row_addr_q <= wgt_row_addr_t'(in_kern + k_ext * wgt_addr_t'(oc_cnt));
            if (cfg.wgt_end) begin
                row_sel_q <= '0;
            end else begin
                row_sel_q <= wgt_sel_t'(1) << kern_row;
            end
            if (oc_wrap) begin
                oc_cnt <= oc_cnt + oc_t'(1);
            end
        end else begin
            oc_cnt     <= '0;
            row_data_q <= '0;
            row_addr_q <= '0;
            row_sel_q  <= '0;
        end
    end

    assign wgt_row_data = row_data_q;
    assign wgt_row_addr = row_addr_q;
    assign wgt_row_en   = row_sel_q;
    assign wgt_row_we   = row_sel_q;

endmodule

// File: hw/row_mem_dist_top.sv
`timescale 1ns/10ps

module row_mem_dist_top import row_mem_pkg::*; (
    input  logic          clk,
    input  logic          resetn,

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    input  logic          start,
    output logic          done,

    // ----------------------------------------------------------------------
    // layer configuration
    // ----------------------------------------------------------------------
    input  oc_t           oc,
    input  img_dim_t      img_h,
    input  img_dim_t      img_w,
    input  kern_t         k,
    input  kern_t         stride,

    // ----------------------------------------------------------------------
    // input streams
    // ----------------------------------------------------------------------
    input  sample_t       act_data,
    input  act_addr_t     act_addr,
    input  sample_t       wgt_data,
    input  wgt_addr_t     wgt_addr,

    // ----------------------------------------------------------------------
    // activation row memories
    // ----------------------------------------------------------------------
    output sample_t       act_row_data,
    output act_row_addr_t act_row_addr,
    output act_sel_t      act_row_en,
    output act_sel_t      act_row_we,

    // ----------------------------------------------------------------------
    // weight row memories
    // ----------------------------------------------------------------------
    output sample_t       wgt_row_data,
    output wgt_row_addr_t wgt_row_addr,
    output wgt_sel_t      wgt_row_en,
    output wgt_sel_t      wgt_row_we
);

    // geometry and status shared by the controller and both scatter units
    load_cfg_if cfg_if ();

    load_ctrl u_ctrl (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .oc       (oc),
        .img_h    (img_h),
        .img_w    (img_w),
        .k        (k),
        .stride   (stride),
        .act_addr (act_addr),
        .wgt_addr (wgt_addr),
        .done     (done),
        .cfg      (cfg_if.ctrl)
    );

    // one image row per activation memory
    act_row_scatter u_act (
        .clk          (clk),
        .resetn       (resetn),
        .act_data     (act_data),
        .act_addr     (act_addr),
        .act_row_data (act_row_data),
        .act_row_addr (act_row_addr),
        .act_row_en   (act_row_en),
        .act_row_we   (act_row_we),
        .cfg          (cfg_if.scatter)
    );

    // one kernel row per weight memory
    weight_row_scatter u_wgt (
        .clk          (clk),
        .resetn       (resetn),
        .wgt_data     (wgt_data),
        .wgt_addr     (wgt_addr),
        .wgt_row_data (wgt_row_data),
        .wgt_row_addr (wgt_row_addr),
        .wgt_row_en   (wgt_row_en),
        .wgt_row_we   (wgt_row_we),
        .cfg          (cfg_if.scatter)
    );

endmodule

// File: tests/row_mem_dist_props.sv
`timescale 1ns/10ps

module row_mem_dist_props import row_mem_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  logic          start,
    input  logic          done,
    input  oc_t           oc,
    input  img_dim_t      img_h,
    input  img_dim_t      img_w,
    input  kern_t         k,
    input  kern_t         stride,
    input  sample_t       act_data,
    input  act_addr_t     act_addr,
    input  sample_t       wgt_data,
    input  wgt_addr_t     wgt_addr,
    input  sample_t       act_row_data,
    input  act_row_addr_t act_row_addr,
    input  act_sel_t      act_row_en,
    input  act_sel_t      act_row_we,
    input  sample_t       wgt_row_data,
    input  wgt_row_addr_t wgt_row_addr,
    input  wgt_sel_t      wgt_row_en,
    input  wgt_sel_t      wgt_row_we
);

    int            in_w;
    int            in_h;
    int            kv;
    int            act_total;
    int            wgt_total;
    load_state_t   st;
    logic          ld_q;
    sample_t       act_d1;
    sample_t       act_d2;
    sample_t       wgt_d1;
    sample_t       wgt_d2;
    act_addr_t     act_a1;
    act_addr_t     act_a2;
    wgt_addr_t     wgt_a1;
    wgt_addr_t     wgt_a2;
    act_row_addr_t exp_act_col;
    act_sel_t      exp_act_sel;
    wgt_row_addr_t exp_wgt_addr;
    wgt_sel_t      exp_wgt_sel;
    int            fail_cnt = 0;

    // ----------------------------------------------------------------------
    // reference geometry
    // ----------------------------------------------------------------------
    always_comb begin
        in_h      = (int'(img_h) - 1) * int'(stride) + int'(k);
        in_w      = (int'(img_w) - 1) * int'(stride) + int'(k);
        act_total = in_h * in_w;
        wgt_total = int'(k) * int'(k) * int'(oc);
        kv        = (k == '0) ? 1 : int'(k);
        // keep the divisions defined for an empty configuration
        if (in_w < 1) begin
            in_w = 1;
        end
    end

    // ----------------------------------------------------------------------
    // reference sequence and two-stage sample history
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            st     <= IDLE;
            ld_q   <= 1'b0;
            act_d1 <= '0;
            act_d2 <= '0;
            wgt_d1 <= '0;
            wgt_d2 <= '0;
            act_a1 <= '0;
            act_a2 <= '0;
            wgt_a1 <= '0;
            wgt_a2 <= '0;
        end else begin
            case (st)
                IDLE: begin
                    if (start) begin
                        st <= LOAD;
                    end
                end
                LOAD: begin
                    if (int'(act_addr) >= act_total && int'(wgt_addr) >= wgt_total) begin
                        st <= DONE;
                    end
                end
                default: begin
                    st <= IDLE;
                end
            endcase
            ld_q   <= (st == LOAD);
            act_d1 <= act_data;
            act_d2 <= act_d1;
            wgt_d1 <= wgt_data;
            wgt_d2 <= wgt_d1;
            act_a1 <= act_addr;
            act_a2 <= act_a1;
            wgt_a1 <= wgt_addr;
            wgt_a2 <= wgt_a1;
        end
    end

    // expected row writes for the sample two edges back
    always_comb begin
        exp_act_col = act_row_addr_t'(int'(act_a2) % in_w);
        exp_act_sel = '0;
        if (int'(act_a2) / in_w < NUM_ACT_ROW_MEM) begin
            exp_act_sel[int'(act_a2) / in_w] = 1'b1;
        end
        exp_wgt_addr = wgt_row_addr_t'(int'(wgt_a2) % kv + kv * (int'(wgt_a2) / (kv * kv)));
        exp_wgt_sel  = '0;
        if (int'(wgt_a2) < wgt_total) begin
            exp_wgt_sel[(int'(wgt_a2) / kv) % kv] = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_done_seq: assert property (@(posedge clk) disable iff (!resetn)
        done == (st == DONE))
    else begin
        fail_cnt++;
        $error("done does not follow the load sequence");
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
    else begin
        fail_cnt++;
        $error("done held for more than one cycle");
    end

    a_quiet: assert property (@(posedge clk) disable iff (!resetn)
        !ld_q |-> (act_row_en == '0 && act_row_we == '0 && act_row_data == '0
                   && act_row_addr == '0 && wgt_row_en == '0 && wgt_row_we == '0
                   && wgt_row_data == '0 && wgt_row_addr == '0))
    else begin
        fail_cnt++;
        $error("row memory outputs active outside LOAD");
    end

    a_act_write: assert property (@(posedge clk) disable iff (!resetn)
        ld_q |-> (act_row_data == act_d2 && act_row_addr == exp_act_col
                  && act_row_en == exp_act_sel && act_row_we == act_row_en))
    else begin
        fail_cnt++;
        $error("activation row write differs from address %0d", act_a2);
    end

    a_wgt_write: assert property (@(posedge clk) disable iff (!resetn)
        ld_q |-> (wgt_row_data == wgt_d2 && wgt_row_addr == exp_wgt_addr
                  && wgt_row_en == exp_wgt_sel && wgt_row_we == wgt_row_en))
    else begin
        fail_cnt++;
        $error("weight row write differs from address %0d", wgt_a2);
    end

endmodule

// File: tests/row_mem_dist_tb.sv
`timescale 1ns/10ps

module row_mem_dist_tb import row_mem_pkg::*; ();

    localparam int NUM_JOBS     = 3;
    localparam int RESET_CYCLES = 16;

    logic          clk;
    logic          resetn;
    logic          start;
    logic          done;
    oc_t           oc;
    img_dim_t      img_h;
    img_dim_t      img_w;
    kern_t         k;
    kern_t         stride;
    sample_t       act_data;
    act_addr_t     act_addr;
    sample_t       wgt_data;
    wgt_addr_t     wgt_addr;
    sample_t       act_row_data;
    act_row_addr_t act_row_addr;
    act_sel_t      act_row_en;
    act_sel_t      act_row_we;
    sample_t       wgt_row_data;
    wgt_row_addr_t wgt_row_addr;
    wgt_sel_t      wgt_row_en;
    wgt_sel_t      wgt_row_we;

    // layer jobs
    int job_oc[NUM_JOBS]     = '{4, 2, 1};
    int job_img_h[NUM_JOBS]  = '{4, 3, 2};
    int job_img_w[NUM_JOBS]  = '{5, 3, 2};
    int job_k[NUM_JOBS]      = '{3, 2, 1};
    int job_stride[NUM_JOBS] = '{2, 1, 1};

    integer seed;
    int     err_cnt;
    int     cycle_cnt;
    int     cycle_limit;

    bind row_mem_dist_top row_mem_dist_props u_props (.*);

    row_mem_dist_top dut0 (.*);

    function automatic int act_total_of(input int j);
        int h;
        int w;
        h = (job_img_h[j] - 1) * job_stride[j] + job_k[j];
        w = (job_img_w[j] - 1) * job_stride[j] + job_k[j];
        return h * w;
    endfunction

    function automatic int wgt_total_of(input int j);
        return job_k[j] * job_k[j] * job_oc[j];
    endfunction

    // ----------------------------------------------------------------------
    // clock and run limit
    // ----------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        #1;
        while (cycle_cnt <= cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        err_cnt++;
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        report_result();
        $finish;
    end

    task automatic report_result();
        int assert_fails;
        assert_fails = dut0.u_props.fail_cnt;
        $display("errors: %0d testbench, %0d assertion", err_cnt, assert_fails);
        if (err_cnt == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
    endtask

    task automatic check_idle();
        if (done !== 1'b0 || act_row_en !== '0 || act_row_we !== '0
            || wgt_row_en !== '0 || wgt_row_we !== '0) begin
            err_cnt++;
            $display("mismatch at %0t: idle outputs done %b act_row_en %h wgt_row_en %b",
                     $time, done, act_row_en, wgt_row_en);
        end
    endtask

    // ----------------------------------------------------------------------
    // one layer job
    // ----------------------------------------------------------------------
    task automatic run_job(input int j);
        int a_tot;
        int w_tot;
        int i;
        int wait_cnt;
        a_tot = act_total_of(j);
        w_tot = wgt_total_of(j);
        // configuration and address 0 go with start
        @(posedge clk);
        oc       <= oc_t'(job_oc[j]);
        img_h    <= img_dim_t'(job_img_h[j]);
        img_w    <= img_dim_t'(job_img_w[j]);
        k        <= kern_t'(job_k[j]);
        stride   <= kern_t'(job_stride[j]);
        start    <= 1'b1;
        act_addr <= '0;
        wgt_addr <= '0;
        act_data <= sample_t'($random(seed));
        wgt_data <= sample_t'($random(seed));
        i = 1;
        while (i <= a_tot || i <= w_tot) begin
            @(posedge clk);
            // stray start while loading
            start    <= (i == 5);
            act_addr <= act_addr_t'((i < a_tot) ? i : a_tot);
            wgt_addr <= wgt_addr_t'((i < w_tot) ? i : w_tot);
            act_data <= sample_t'($random(seed));
            wgt_data <= sample_t'($random(seed));
            i++;
        end
        @(posedge clk);
        // stray start while in DONE
        start <= 1'b1;
        wait_cnt = 0;
        do begin
            @(negedge clk);
            wait_cnt++;
        end while (done !== 1'b1 && wait_cnt < 30);
        if (done !== 1'b1) begin
            err_cnt++;
            $display("job %0d: done missing within 30 cycles after both streams ended", j);
        end
        @(posedge clk);
        start <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
    endtask

    initial begin
        int j;
        seed        = 32'hbaa7_e3a5;
        err_cnt     = 0;
        cycle_limit = RESET_CYCLES;
        for (j = 0; j < NUM_JOBS; j++) begin
            cycle_limit += ((act_total_of(j) > wgt_total_of(j)) ?
                            act_total_of(j) : wgt_total_of(j)) + 20;
        end
        resetn   <= 1'b0;
        start    <= 1'b0;
        oc       <= oc_t'(job_oc[0]);
        img_h    <= img_dim_t'(job_img_h[0]);
        img_w    <= img_dim_t'(job_img_w[0]);
        k        <= kern_t'(job_k[0]);
        stride   <= kern_t'(job_stride[0]);
        act_data <= '0;
        act_addr <= '0;
        wgt_data <= '0;
        wgt_addr <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_idle();
        for (j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        report_result();
        $finish;
    end

endmodule

// File: src.f
hw/row_mem_pkg.sv
hw/load_cfg_if.sv
hw/load_ctrl.sv
hw/act_row_scatter.sv
hw/weight_row_scatter.sv
hw/row_mem_dist_top.sv
tests/row_mem_dist_props.sv
tests/row_mem_dist_tb.sv
